//--- include/barrel_defines.svh
/*
 * Global sizing for the barrel fetch front end: thread count, PC width,
 * read-to-write pipeline distance and per-thread start addresses
 */

`ifndef BARREL_DEFINES_SVH
`define BARREL_DEFINES_SVH

// Hardware threads sharing the fetch slot, at least 3
`define BARREL_THREAD_COUNT 4
`define BARREL_THREAD_WIDTH 2

// Program counter width
`define BARREL_PC_WIDTH 10

// Cycles the read thread runs ahead of the write thread
`define BARREL_STAGE_COUNT 2

// Start address of thread n is BASE + n * STRIDE
`define BARREL_START_BASE 10'h040
`define BARREL_START_STRIDE 10'h080

`endif

//--- rtl/barrel_pkg.sv
/*
 * Shared types for the barrel fetch front end: PC and thread id vectors,
 * boot sequencer states
 */

`include "barrel_defines.svh"

package barrel_pkg;

    // Instruction address
    typedef logic [`BARREL_PC_WIDTH-1:0] pc_t;

    // Hardware thread number
    typedef logic [`BARREL_THREAD_WIDTH-1:0] thread_t;

    // Boot sequencer, memory fill then normal issue
    typedef enum logic {BOOT_FILL, BOOT_RUN} boot_state_t;

endpackage

//--- rtl/thread_counter.sv
/*
 * Round-robin thread id counter with a loadable start value
 * and a flag on the last thread id
 */

`timescale 1ns/1ps
`include "barrel_defines.svh"

module thread_counter import barrel_pkg::*; #(
    parameter thread_t start_thread = '0
) (
    input  logic    clock,
    input  logic    rst_n,
    output thread_t thread,
    output logic    last
);

    // Highest thread id before wrapping
    localparam thread_t LAST_THREAD = thread_t'(`BARREL_THREAD_COUNT - 1);

    assign last = (thread == LAST_THREAD);

    // Step once per cycle, wrap to thread 0 after the last one
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread <= start_thread;
        end else if (last) begin
            thread <= '0;
        end else begin
            thread <= thread + thread_t'(1);
        end
    end

endmodule

//--- rtl/pc_ram.sv
/*
 * Simple dual-port PC store, one word per thread
 * One write port, one registered read port
 */

`timescale 1ns/1ps
`include "barrel_defines.svh"

module pc_ram import barrel_pkg::*; (
    input  logic    clock,
    input  logic    write_enable,
    input  thread_t write_thread,
    input  pc_t     write_data,
    input  thread_t read_thread,
    output pc_t     read_data
);

    // One entry per hardware thread
    pc_t mem [`BARREL_THREAD_COUNT];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_thread] <= write_data;
        end
    end

    // Registered read, old data on a same-address collision
    always_ff @(posedge clock) begin
        read_data <= mem[read_thread];
    end

endmodule

//--- rtl/pc_boot_fsm.sv
/*
 * Boot sequencer: one full thread rotation of memory fill after reset,
 * then normal PC issue until the next reset
 */

`timescale 1ns/1ps
`include "barrel_defines.svh"

module pc_boot_fsm import barrel_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    input  logic write_last,
    output logic boot_fill,
    output logic pc_valid
);

    boot_state_t state;
    boot_state_t state_next;

    // ----------------------------------------
    // Next state

    always_comb begin
        state_next = state;
        case (state)
            // Fill ends once the write counter has visited every thread
            BOOT_FILL: if (write_last) state_next = BOOT_RUN;
            // Run is terminal until reset
            BOOT_RUN:  state_next = BOOT_RUN;
            default:   state_next = BOOT_FILL;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= BOOT_FILL;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------
    // Outputs decoded from state

    assign boot_fill = (state == BOOT_FILL);
    assign pc_valid  = (state == BOOT_RUN);

endmodule

//--- rtl/thread_pc_controller.sv
/*
 * Two-stage per-thread PC datapath: current and previous PC memories,
 * re-issue / jump / sequential selection, write-back of PC plus one,
 * start address fill during boot
 */

`timescale 1ns/1ps
`include "barrel_defines.svh"

module thread_pc_controller import barrel_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  logic    boot_fill,
    input  thread_t read_thread,
    input  thread_t write_thread,
    input  logic    io_ready,
    input  logic    cancel,
    input  logic    jump,
    input  pc_t     jump_destination,
    output pc_t     pc
);

    // Start address of the thread being written back
    pc_t start_pc;
    // Write-back data for both memories
    pc_t current_write;
    pc_t previous_write;
    // Stored PCs of the thread read last cycle
    pc_t pc_current;
    pc_t pc_previous;
    // Control inputs aligned with the memory read data
    logic io_ready_s1;
    logic cancel_s1;
    logic jump_s1;
    pc_t  jump_destination_s1;
    // Stage 1 selection
    logic reissue;
    pc_t  pc_select;

    // ----------------------------------------
    // Write-back, at the thread now on pc

    assign start_pc = pc_t'(`BARREL_START_BASE)
                    + pc_t'(write_thread) * pc_t'(`BARREL_START_STRIDE);

    // Boot loads both memories with the start address
    assign current_write  = boot_fill ? start_pc : pc + pc_t'(1);
    assign previous_write = boot_fill ? start_pc : pc;

    // ----------------------------------------
    // Stage 0: memory reads and input capture

    pc_ram current_mem (
        .clock        (clock),
        .write_enable (1'b1),
        .write_thread (write_thread),
        .write_data   (current_write),
        .read_thread  (read_thread),
        .read_data    (pc_current)
    );

    pc_ram previous_mem (
        .clock        (clock),
        .write_enable (1'b1),
        .write_thread (write_thread),
        .write_data   (previous_write),
        .read_thread  (read_thread),
        .read_data    (pc_previous)
    );

    // Idle values: ready, no cancel, no jump
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_ready_s1 <= 1'b1;
            cancel_s1   <= 1'b0;
            jump_s1     <= 1'b0;
        end else begin
            io_ready_s1 <= io_ready;
            cancel_s1   <= cancel;
            jump_s1     <= jump;
        end
    end

    // Destination is payload only, qualified by jump_s1
    always_ff @(posedge clock) begin
        jump_destination_s1 <= jump_destination;
    end

    // ----------------------------------------
    // Stage 1: PC selection

    // I/O not ready re-issues the last PC, unless it was cancelled
    assign reissue = !io_ready_s1 && !cancel_s1;

    // Re-issue has priority over a jump
    always_comb begin
        if (reissue) begin
            pc_select = pc_previous;
        end else if (jump_s1) begin
            pc_select = jump_destination_s1;
        end else begin
            pc_select = pc_current;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc <= pc_t'(`BARREL_START_BASE);
        end else begin
            pc <= pc_select;
        end
    end

endmodule

//--- rtl/barrel_fetch_top.sv
/*
 * Barrel fetch front end top level
 * Thread counters, boot sequencer and PC controller
 */

`timescale 1ns/1ps
`include "barrel_defines.svh"

module barrel_fetch_top import barrel_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  logic    io_ready,
    input  logic    cancel,
    input  logic    jump,
    input  pc_t     jump_destination,
    output pc_t     pc,
    output thread_t pc_thread,
    output logic    pc_valid
);

    thread_t read_thread;
    logic    write_last;
    logic    boot_fill;

    // ----------------------------------------
    // Thread counters

    // Read side leads the output thread by the pipeline depth
    thread_counter #(
        .start_thread (thread_t'(`BARREL_STAGE_COUNT))
    ) read_count (
        .clock  (clock),
        .rst_n  (rst_n),
        .thread (read_thread),
        .last   ()
    );

    // Write side names the thread whose PC is on the output
    thread_counter #(
        .start_thread (thread_t'(0))
    ) write_count (
        .clock  (clock),
        .rst_n  (rst_n),
        .thread (pc_thread),
        .last   (write_last)
    );

    // ----------------------------------------
    // Boot sequencer and datapath

    pc_boot_fsm boot_fsm (
        .clock      (clock),
        .rst_n      (rst_n),
        .write_last (write_last),
        .boot_fill  (boot_fill),
        .pc_valid   (pc_valid)
    );

    thread_pc_controller pc_ctrl (
        .clock            (clock),
        .rst_n            (rst_n),
        .boot_fill        (boot_fill),
        .read_thread      (read_thread),
        .write_thread     (pc_thread),
        .io_ready         (io_ready),
        .cancel           (cancel),
        .jump             (jump),
        .jump_destination (jump_destination),
        .pc               (pc)
    );

endmodule

//--- bench/barrel_fetch_properties.sv
/*
 * Bound checks on the barrel fetch PC stream: boot timing, thread rotation,
 * sequential, jump, re-issue and cancel selection
 */

`timescale 1ns/1ps
`include "barrel_defines.svh"

module barrel_fetch_properties import barrel_pkg::*; (
    input logic    clock,
    input logic    rst_n,
    input logic    io_ready,
    input logic    cancel,
    input logic    jump,
    input pc_t     jump_destination,
    input pc_t     pc,
    input thread_t pc_thread,
    input logic    pc_valid
);

    localparam int THREADS = `BARREL_THREAD_COUNT;
    localparam int STAGES  = `BARREL_STAGE_COUNT;

    // Failed assertions, summed into the testbench error count
    int failures = 0;

    // Saturating count of cycles since reset release
    int run_cycles;
    // History where index n holds the value seen n cycles back
    pc_t  [THREADS:1] pc_hist;
    logic [THREADS:1] valid_hist;
    logic [STAGES:1]  ready_hist;
    logic [STAGES:1]  cancel_hist;
    logic [STAGES:1]  jump_hist;
    pc_t  [STAGES:1]  dest_hist;
    thread_t          thread_prev;

    // Expected values
    logic    valid_expect;
    logic    first_rotation;
    pc_t     start_expect;
    pc_t     seq_expect;
    thread_t thread_expect;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            run_cycles <= 0;
            valid_hist <= '0;
        end else begin
            if (run_cycles < 2 * THREADS) begin
                run_cycles <= run_cycles + 1;
            end
            valid_hist <= {valid_hist[THREADS-1:1], pc_valid};
        end
        pc_hist     <= {pc_hist[THREADS-1:1], pc};
        ready_hist  <= {ready_hist[STAGES-1:1], io_ready};
        cancel_hist <= {cancel_hist[STAGES-1:1], cancel};
        jump_hist   <= {jump_hist[STAGES-1:1], jump};
        dest_hist   <= {dest_hist[STAGES-1:1], jump_destination};
        thread_prev <= pc_thread;
    end

    // One rotation of fill, then valid for good
    assign valid_expect   = (run_cycles >= THREADS);
    assign first_rotation = valid_expect && (run_cycles < 2 * THREADS);

    // Base plus thread id times stride
    assign start_expect = pc_t'(`BARREL_START_BASE)
                        + pc_t'(pc_thread) * pc_t'(`BARREL_START_STRIDE);

    // Next sequential PC of this thread, wraps at the PC width
    assign seq_expect = pc_hist[THREADS] + pc_t'(1);

    assign thread_expect = (thread_prev == thread_t'(THREADS - 1)) ? thread_t'(0)
                                                                    : thread_prev + thread_t'(1);

    // ----------------------------------------
    // Boot timing and thread rotation

    boot_timing: assert property (@(posedge clock) disable iff (!rst_n)
        pc_valid == valid_expect)
    else begin
        $error("FAIL pc_valid: got %h, expected %h",
               $sampled(pc_valid), $sampled(valid_expect));
        failures++;
    end

    boot_start_pc: assert property (@(posedge clock) disable iff (!rst_n)
        first_rotation |-> pc == start_expect)
    else begin
        $error("FAIL pc: got %h, expected %h", $sampled(pc), $sampled(start_expect));
        failures++;
    end

    thread_rotation: assert property (@(posedge clock) disable iff (!rst_n)
        pc_valid && valid_hist[1] |-> pc_thread == thread_expect)
    else begin
        $error("FAIL pc_thread: got %h, expected %h",
               $sampled(pc_thread), $sampled(thread_expect));
        failures++;
    end

    // ----------------------------------------
    // PC selection, controls taken STAGES cycles back

    sequential_pc: assert property (@(posedge clock) disable iff (!rst_n)
        pc_valid && valid_hist[THREADS] && ready_hist[STAGES] && !jump_hist[STAGES]
        |-> pc == seq_expect)
    else begin
        $error("FAIL pc: got %h, expected %h", $sampled(pc), $sampled(seq_expect));
        failures++;
    end

    jump_pc: assert property (@(posedge clock) disable iff (!rst_n)
        pc_valid && (ready_hist[STAGES] || cancel_hist[STAGES]) && jump_hist[STAGES]
        |-> pc == dest_hist[STAGES])
    else begin
        $error("FAIL pc: got %h, expected %h", $sampled(pc), $sampled(dest_hist[STAGES]));
        failures++;
    end

    // Re-issue wins over a jump
    reissue_pc: assert property (@(posedge clock) disable iff (!rst_n)
        pc_valid && valid_hist[THREADS] && !ready_hist[STAGES] && !cancel_hist[STAGES]
        |-> pc == pc_hist[THREADS])
    else begin
        $error("FAIL pc: got %h, expected %h", $sampled(pc), $sampled(pc_hist[THREADS]));
        failures++;
    end

    cancel_pc: assert property (@(posedge clock) disable iff (!rst_n)
        pc_valid && valid_hist[THREADS] && !ready_hist[STAGES] && cancel_hist[STAGES]
        && !jump_hist[STAGES] |-> pc == seq_expect)
    else begin
        $error("FAIL pc: got %h, expected %h", $sampled(pc), $sampled(seq_expect));
        failures++;
    end

endmodule

bind barrel_fetch_top barrel_fetch_properties barrel_checks (
    .clock            (clock),
    .rst_n            (rst_n),
    .io_ready         (io_ready),
    .cancel           (cancel),
    .jump             (jump),
    .jump_destination (jump_destination),
    .pc               (pc),
    .pc_thread        (pc_thread),
    .pc_valid         (pc_valid)
);

//--- bench/barrel_fetch_tb.sv
/*
 * Barrel fetch testbench: clock, reset, LFSR stimulus phases,
 * pc_valid wait and closing error summary
 */

`timescale 1ns/1ps
`include "barrel_defines.svh"

module barrel_fetch_tb import barrel_pkg::*; ();

    localparam int          CLOCK_PERIOD  = 100;
    localparam int          RESET_CYCLES  = 8;
    localparam int          VALID_TIMEOUT = 4 * `BARREL_THREAD_COUNT;
    localparam logic [31:0] LFSR_SEED     = 32'h6803def8;
    // Feedback mask for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

    // Stimulus phases
    localparam int PHASE_QUIET  = 0;
    localparam int PHASE_JUMP   = 1;
    localparam int PHASE_STALL  = 2;
    localparam int PHASE_CANCEL = 3;
    localparam int PHASE_MIXED  = 4;

    logic    clock;
    logic    rst_n;
    logic    io_ready;
    logic    cancel;
    logic    jump;
    pc_t     jump_destination;
    pc_t     pc;
    thread_t pc_thread;
    logic    pc_valid;

    logic [31:0] lfsr_state;
    int          errors;

    barrel_fetch_top barrel_fetch_top_i (
        .clock            (clock),
        .rst_n            (rst_n),
        .io_ready         (io_ready),
        .cancel           (cancel),
        .jump             (jump),
        .jump_destination (jump_destination),
        .pc               (pc),
        .pc_thread        (pc_thread),
        .pc_valid         (pc_valid)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    // ----------------------------------------
    // Random source

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    // One LFSR step per bit taken, low bit is the newest
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // ----------------------------------------
    // Stimulus

    // Inputs for one cycle, set on the falling edge
    task automatic drive_cycle(input int phase);
        @(negedge clock);
        io_ready         = 1'b1;
        cancel           = 1'b0;
        jump             = 1'b0;
        jump_destination = pc_t'(random_bits(`BARREL_PC_WIDTH));
        case (phase)
            PHASE_JUMP: begin
                jump = (random_bits(2) == 0);
            end
            PHASE_STALL: begin
                io_ready = (random_bits(2) != 0);
            end
            // Half the cycles not ready, cancel at random on top
            PHASE_CANCEL: begin
                io_ready = (random_bits(1) != 0);
                cancel   = (random_bits(1) != 0);
            end
            PHASE_MIXED: begin
                io_ready = (random_bits(2) != 0);
                cancel   = (random_bits(1) != 0);
                jump     = (random_bits(2) == 0);
            end
            default: begin
            end
        endcase
    endtask

    task automatic wait_for_valid(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < VALID_TIMEOUT && !seen; n++) begin
            @(negedge clock);
            seen = pc_valid;
        end
        if (!seen) begin
            errors++;
            $display("pc_valid did not go high within %0d cycles of reset release",
                     VALID_TIMEOUT);
        end
    endtask

    initial begin
        logic valid_seen;
        int   failures;
        int   total;

        rst_n            = 1'b0;
        io_ready         = 1'b1;
        cancel           = 1'b0;
        jump             = 1'b0;
        jump_destination = '0;
        lfsr_state       = LFSR_SEED;
        errors           = 0;

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // Inputs stay idle through the boot fill and the first rotation
        wait_for_valid(valid_seen);
        if (valid_seen) begin
            repeat (40) drive_cycle(PHASE_QUIET);
            repeat (160) drive_cycle(PHASE_JUMP);
            repeat (160) drive_cycle(PHASE_STALL);
            repeat (160) drive_cycle(PHASE_CANCEL);
            repeat (320) drive_cycle(PHASE_MIXED);
            // Flush the last controls through to pc
            repeat (2 * `BARREL_THREAD_COUNT) drive_cycle(PHASE_QUIET);
        end

        failures = barrel_fetch_top_i.barrel_checks.failures;
        total    = errors + failures;
        $display("Errors: testbench %0d, assertions %0d, total %0d", errors, failures, total);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
rtl/barrel_pkg.sv
rtl/thread_counter.sv
rtl/pc_ram.sv
rtl/pc_boot_fsm.sv
rtl/thread_pc_controller.sv
rtl/barrel_fetch_top.sv
bench/barrel_fetch_properties.sv
bench/barrel_fetch_tb.sv

//--- Makefile
# Verilator build and run of the barrel fetch testbench

VERILATOR ?= verilator
TOP       ?= barrel_fetch_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILE_LIST)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
